// File: vlog.f
+incdir+hw
hw/samplePkg.sv
hw/triggerPkg.sv
hw/channelTrigger.sv
hw/coincidenceTrigger.sv
hw/acquireControl.sv
hw/sampleAverager.sv
hw/scopeCore.sv
bench/scopeTbAsserts.sv
bench/scopeTb.sv

// File: Makefile
# Verilator flow for the scope acquisition core

OBJ = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module scopeCore -f vlog.f

sim:
	verilator --binary --timing --assert --top-module scopeTb -Mdir $(OBJ) -f vlog.f
	./$(OBJ)/VscopeTb

clean:
	rm -rf $(OBJ)

// File: bench/scopeTb.sv
`timescale 1ns/1ps
`include "scope_consts.svh"

module scopeTb;
	import samplePkg::*;
	import triggerPkg::*;

	localparam int NSMP = 40;
	localparam int TPOINT = 16;
	localparam int LIMIT = 4 * (6 * (NSMP + 1) * 4) + 1000; // six tests at downsample 2, plus margin
	localparam logic [7:0] LEVEL = 8'd77; // high-res constant

	logic clk_flash = 1'b0;
	logic rstN;
	sample_t flashData [`SCOPE_NCH];
	sample_t threshLow, threshHigh;
	logic fallingEdge, allowSameChan, noSelfTrig, isFirst, isLast, startTrigger, highRes;
	tot_t tot;
	logic [`SCOPE_NCH-1:0] chanEnable;
	coinCount_t coinReq;
	holdTime_t holdTime;
	chain_t trigIn, trigOut;
	addr_t triggerPoint, nsmp, wrAddress, trigPointAddr;
	dsExp_t downsample;
	logic trigger, acquiring, dataReady;
	logic [`SCOPE_NCH-1:0] inRange;
	sample_t dout [`SCOPE_NCH];
	logic [`SCOPE_NCH*`SCOPE_SAMPLE_W-1:0] doutBus, flashBus;
	logic failed;
	int testId;
	int cycles;
	int seed = 32'hb320;
	logic [`SCOPE_NCH-1:0] forceHigh; // channels held inside the window
	logic quiet; // all inputs at 0
	logic wideNoise; // full range samples

	always #50 clk_flash = ~clk_flash;

	scopeCore uut (.*);

	assign doutBus = {dout[0], dout[1], dout[2], dout[3]};
	assign flashBus = {flashData[0], flashData[1], flashData[2], flashData[3]};

	scopeTbAsserts checks (.*, .level(LEVEL));

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped");
	endtask

	// one falling edge, new samples on every channel
	task automatic tick(input int n);
		repeat (n) begin
			@(negedge clk_flash);
			for (int i = 0; i < `SCOPE_NCH; i++) begin
				if (quiet) flashData[i] = '0;
				else if (forceHigh[i]) flashData[i] = 8'd150;
				else if (wideNoise) flashData[i] = sample_t'({$random(seed)});
				else flashData[i] = sample_t'({$random(seed)} % 100); // below threshLow
			end
		end
	endtask

	task automatic acquireOnce(input int trigDelay);
		tick(1);
		startTrigger = 1'b1;
		tick(1);
		startTrigger = 1'b0;
		tick(trigDelay); // past the pre-trigger fill
		forceHigh[0] = 1'b1;
		while (!dataReady) tick(1);
		forceHigh[0] = 1'b0;
		tick(3);
	endtask

	always @(posedge clk_flash) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) stopWithFailure("timeout: the run did not finish in time");
	end

	always @(posedge failed) stopWithFailure("a check failed");

	initial begin
		rstN = 1'b0;
		cycles = 0;
		testId = 0;
		quiet = 1'b1;
		wideNoise = 1'b0;
		forceHigh = '0;
		for (int i = 0; i < `SCOPE_NCH; i++) flashData[i] = '0;
		threshLow = 8'd100;
		threshHigh = 8'd200;
		fallingEdge = 1'b0;
		tot = '0;
		chanEnable = 4'b0001;
		coinReq = '0;
		holdTime = 8'd10;
		allowSameChan = 1'b0;
		noSelfTrig = 1'b0;
		isFirst = 1'b0;
		isLast = 1'b0;
		trigIn = '0;
		startTrigger = 1'b0;
		triggerPoint = addr_t'(TPOINT);
		nsmp = addr_t'(NSMP);
		downsample = '0;
		highRes = 1'b0;
		tick(5);
		rstN = 1'b1;
		testId = 1;
		tick(3);
		testId = 2;
		quiet = 1'b0;
		acquireOnce(30);
		testId = 3;
		downsample = 5'd2;
		acquireOnce(100); // pre-trigger fill takes 16 * 4 clocks
		testId = 0;
		quiet = 1'b1;
		tick(1);
		quiet = 1'b0;
		for (int i = 0; i < `SCOPE_NCH; i++) flashData[i] = LEVEL;
		repeat (2) @(negedge clk_flash);
		highRes = 1'b1;
		repeat (12) @(negedge clk_flash); // first window may be partial
		testId = 4;
		repeat (12) @(negedge clk_flash);
		testId = 0;
		highRes = 1'b0;
		wideNoise = 1'b1;
		tick(2);
		testId = 5;
		tick(20);
		testId = 0;
		wideNoise = 1'b0;
		downsample = '0;
		coinReq = 2'd1;
		chanEnable = '1;
		tick(20); // let the hold timers run out
		testId = 6;
		repeat (2) begin
			forceHigh[0] = 1'b1;
			tick(3);
			forceHigh[0] = 1'b0;
			tick(3);
		end
		tick(5);
		testId = 7;
		forceHigh[1] = 1'b1;
		tick(3);
		forceHigh[2] = 1'b1;
		tick(8);
		forceHigh = '0;
		tick(2);
		testId = 0;
		noSelfTrig = 1'b1;
		tick(1);
		testId = 8;
		repeat (20) begin
			trigIn = chain_t'({$random(seed)});
			tick(1);
		end
		testId = 0;
		tick(2);
		if (failed) begin
			stopWithFailure("a check failed");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

// File: bench/scopeTbAsserts.sv
`timescale 1ns/1ps
`include "scope_consts.svh"

module scopeTbAsserts (
	input logic clk_flash,
	input int testId, // which check window is open, 0 means none
	input logic acquiring,
	input logic dataReady,
	input logic trigger,
	input logic [`SCOPE_NCH-1:0] inRange,
	input logic [1:0] trigIn,
	input logic [1:0] trigOut,
	input triggerPkg::addr_t wrAddress,
	input triggerPkg::addr_t trigPointAddr,
	input triggerPkg::addr_t nsmp,
	input triggerPkg::addr_t triggerPoint,
	input samplePkg::sample_t threshLow,
	input samplePkg::sample_t threshHigh,
	input logic [`SCOPE_NCH*`SCOPE_SAMPLE_W-1:0] doutBus, // channel 0 in the top byte
	input logic [`SCOPE_NCH*`SCOPE_SAMPLE_W-1:0] flashBus,
	input logic [`SCOPE_SAMPLE_W-1:0] level, // constant input of the high-res test
	output logic failed
);
	import triggerPkg::*;

	int prevTestId;
	addr_t prevAddr;
	logic addrMoved;
	int gap; // cycles since wrAddress last moved
	logic gapValid; // a move was seen inside the downsample test
	logic [`SCOPE_NCH*`SCOPE_SAMPLE_W-1:0] flashDly1;
	logic [`SCOPE_NCH*`SCOPE_SAMPLE_W-1:0] flashDly2; // input register plus output register
	logic trigInDly;
	logic sawRight; // trigOut[1] seen in the coincidence test

	initial failed = 1'b0;

	function automatic string testName(input int id);
		case (id)
			1: return "reset";
			2: return "single trigger";
			3: return "downsample";
			4: return "high-res average";
			5: return "pass-through";
			6: return "lone channel";
			7: return "coincidence";
			8: return "noSelfTrig";
			default: return "idle";
		endcase
	endfunction

	// channel i sits in byte NCH-1-i of the bus, both bounds inside the window
	function automatic logic [`SCOPE_NCH-1:0] windowHits(
		input logic [`SCOPE_NCH*`SCOPE_SAMPLE_W-1:0] bus);
		logic [`SCOPE_SAMPLE_W-1:0] s;
		logic [`SCOPE_NCH-1:0] hits;
		for (int i = 0; i < `SCOPE_NCH; i++) begin
			s = bus[(`SCOPE_NCH-1-i)*`SCOPE_SAMPLE_W +: `SCOPE_SAMPLE_W];
			hits[i] = !((s < threshLow) || (s > threshHigh));
		end
		return hits;
	endfunction

	task automatic reportMismatch(input longint expected, input longint actual);
		$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", testName(testId), expected, actual);
		failed = 1'b1;
	endtask

	assign addrMoved = wrAddress != prevAddr;

	always_ff @(posedge clk_flash) begin
		prevTestId <= testId;
		prevAddr <= wrAddress;
		flashDly1 <= flashBus;
		flashDly2 <= flashDly1;
		trigInDly <= trigIn[1];
		gap <= addrMoved ? 1 : gap + 1;
		if (testId != 3) begin
			gapValid <= 1'b0;
		end else if (addrMoved) begin
			gapValid <= 1'b1; // first move only sets the phase
		end
		if (testId != 7) begin
			sawRight <= 1'b0;
		end else if (trigOut[1]) begin
			sawRight <= 1'b1;
		end
	end

	assert property (@(posedge clk_flash) testId == 1 |->
		!acquiring && !dataReady && trigOut == 2'b00 && doutBus == '0)
		else reportMismatch(0, longint'({acquiring, dataReady, trigOut, doutBus}));

	// distance from trigger slot to the end of the buffer
	assert property (@(posedge clk_flash) $rose(dataReady) |->
		addr_t'(wrAddress - trigPointAddr) == addr_t'(nsmp - triggerPoint))
		else reportMismatch(longint'(addr_t'(nsmp - triggerPoint)),
			longint'(addr_t'(wrAddress - trigPointAddr)));

	assert property (@(posedge clk_flash) (testId == 3 && addrMoved && gapValid) |->
		gap == 4 && wrAddress == addr_t'(prevAddr + 1'b1))
		else reportMismatch(4, longint'(gap)); // one step per 2^2 clocks

	assert property (@(posedge clk_flash) testId == 4 |-> doutBus == {`SCOPE_NCH{level}})
		else reportMismatch(longint'({`SCOPE_NCH{level}}), longint'(doutBus));

	assert property (@(posedge clk_flash) testId == 5 |-> doutBus == flashDly2)
		else reportMismatch(longint'(flashDly2), longint'(doutBus));

	// window state trails the pins by the input register and the compare register
	assert property (@(posedge clk_flash) testId == 5 |-> inRange == windowHits(flashDly2))
		else reportMismatch(longint'(windowHits(flashDly2)), longint'(inRange));

	assert property (@(posedge clk_flash) testId == 6 |-> trigOut == 2'b00)
		else reportMismatch(0, longint'(trigOut));

	assert property (@(posedge clk_flash) (prevTestId == 7 && testId != 7) |-> sawRight)
		else reportMismatch(1, 0); // trigOut[1] never went high

	assert property (@(posedge clk_flash) (testId == 8 && prevTestId == 8) |->
		trigOut == {trigInDly, 1'b0} && trigger == trigInDly)
		else reportMismatch(longint'({trigInDly, trigInDly, 1'b0}),
			longint'({trigger, trigOut}));

endmodule

// File: hw/scopeCore.sv
`timescale 1ns/1ps
`include "scope_consts.svh"

module scopeCore (
	input logic clk_flash,
	input logic rstN,
	input samplePkg::sample_t flashData [`SCOPE_NCH], // adc data pins
	input samplePkg::sample_t threshLow, // trigger window, shared by all channels
	input samplePkg::sample_t threshHigh,
	input logic fallingEdge,
	input triggerPkg::tot_t tot,
	input logic [`SCOPE_NCH-1:0] chanEnable,
	input triggerPkg::coinCount_t coinReq,
	input triggerPkg::holdTime_t holdTime,
	input logic allowSameChan,
	input logic noSelfTrig,
	input logic isFirst,
	input logic isLast,
	input triggerPkg::chain_t trigIn, // daisy chain from the neighbors
	input logic startTrigger,
	input triggerPkg::addr_t triggerPoint,
	input triggerPkg::addr_t nsmp,
	input samplePkg::dsExp_t downsample,
	input logic highRes,
	output triggerPkg::chain_t trigOut, // daisy chain to the neighbors
	output logic trigger,
	output logic [`SCOPE_NCH-1:0] inRange, // per channel window state
	output logic acquiring,
	output logic dataReady,
	output triggerPkg::addr_t wrAddress,
	output triggerPkg::addr_t trigPointAddr,
	output samplePkg::sample_t dout [`SCOPE_NCH] // samples for the buffer
);
	import samplePkg::*;

	sample_t samples [`SCOPE_NCH]; // adc pins one clock later
	logic [`SCOPE_NCH-1:0] fire;
	logic dsGo;

	always_ff @(posedge clk_flash) begin
		samples <= flashData; // capture right at the pads
	end

	for (genvar i = 0; i < `SCOPE_NCH; i++) begin : gChan
		channelTrigger uChan (
			.sample(samples[i]),
			.fire(fire[i]),
			.inRange(inRange[i]),
			.*
		);
	end

	coincidenceTrigger uCoin (.*);

	acquireControl uAcq (.*);

	sampleAverager uAvg (.*);

endmodule

// File: hw/sampleAverager.sv
`timescale 1ns/1ps
`include "scope_consts.svh"

module sampleAverager (
	input logic clk_flash,
	input logic rstN,
	input samplePkg::sample_t samples [`SCOPE_NCH], // registered adc samples
	input logic highRes, // average over the downsample window
	input logic dsGo,
	input samplePkg::dsExp_t downsample,
	output samplePkg::sample_t dout [`SCOPE_NCH]
);
	import samplePkg::*;

	sampleAcc_t acc [`SCOPE_NCH]; // running sum per channel
	sampleAcc_t accSum [`SCOPE_NCH]; // sum including this sample
	sampleAcc_t accShift [`SCOPE_NCH]; // sum scaled back to a sample
	hrCount_t hrCount;
	hrCount_t hrNext;
	dsExp_t shiftBy; // log2 of the window length
	logic flush; // window ends this cycle

	assign shiftBy = (downsample > dsExp_t'(`SCOPE_MAXHIGHRES)) ?
		dsExp_t'(`SCOPE_MAXHIGHRES) : downsample;
	assign hrNext = hrCount + 1'b1;
	assign flush = dsGo || hrNext[`SCOPE_MAXHIGHRES]; // long windows cut at 2^maxhighres

	always_comb begin
		for (int i = 0; i < `SCOPE_NCH; i++) begin
			accSum[i] = acc[i] + sampleAcc_t'(samples[i]);
			accShift[i] = accSum[i] >> shiftBy;
		end
	end

	always_ff @(posedge clk_flash) begin
		if (!rstN) begin
			hrCount <= '0;
			for (int i = 0; i < `SCOPE_NCH; i++) begin
				acc[i] <= '0;
				dout[i] <= '0;
			end
		end else if (highRes) begin
			hrCount <= flush ? '0 : hrNext;
			for (int i = 0; i < `SCOPE_NCH; i++) begin
				if (flush) begin
					dout[i] <= accShift[i][`SCOPE_SAMPLE_W-1:0];
					acc[i] <= '0; // next window starts empty
				end else begin
					acc[i] <= accSum[i];
				end
			end
		end else begin
			hrCount <= '0;
			for (int i = 0; i < `SCOPE_NCH; i++) begin
				acc[i] <= '0;
				dout[i] <= samples[i]; // straight copy
			end
		end
	end

endmodule

// File: hw/acquireControl.sv
`timescale 1ns/1ps
`include "scope_consts.svh"

module acquireControl (
	input logic clk_flash,
	input logic rstN,
	input logic startTrigger, // arm a new acquisition
	input logic trigger, // board trigger
	input triggerPkg::addr_t triggerPoint, // samples kept before the trigger
	input triggerPkg::addr_t nsmp, // total samples per acquisition
	input samplePkg::dsExp_t downsample, // keep one sample in 2^downsample
	output logic dsGo, // one cycle in every 2^downsample
	output logic acquiring,
	output triggerPkg::addr_t wrAddress, // next ring buffer slot
	output triggerPkg::addr_t trigPointAddr, // slot written at the trigger
	output logic dataReady // buffer complete, ready to read
);
	import samplePkg::*;
	import triggerPkg::*;

	acqState_t state;
	addr_t sampleCount; // pre then post trigger samples
	dsExp_t dsEff; // exponent clamped to the counter range
	logic [`SCOPE_DS_MAX:0] dsCount;
	logic postDone; // last post-trigger sample is in
	logic wrStep; // advance the write address

	assign dsEff = (downsample > dsExp_t'(`SCOPE_DS_MAX)) ? dsExp_t'(`SCOPE_DS_MAX) : downsample;
	assign dsGo = (dsEff == '0) || dsCount[dsEff];
	assign postDone = (state == POSTACQ) && (sampleCount == nsmp);
	assign wrStep = dsGo && acquiring && !postDone;

	// free running strobe counter, restarts at 1 on every dsGo
	always_ff @(posedge clk_flash) begin
		if (!rstN || dsGo) begin
			dsCount <= {{`SCOPE_DS_MAX{1'b0}}, 1'b1};
		end else begin
			dsCount <= dsCount + 1'b1;
		end
	end

	always_ff @(posedge clk_flash) begin
		if (!rstN) begin
			state <= INIT;
			acquiring <= 1'b0;
			dataReady <= 1'b0;
			wrAddress <= '0;
			sampleCount <= '0;
		end else begin
			if (wrStep) begin
				wrAddress <= wrAddress + 1'b1; // ring buffer wraps by itself
			end
			case (state)
				INIT: begin
					if (startTrigger) begin
						sampleCount <= '0;
						acquiring <= 1'b1;
						dataReady <= 1'b0; // old buffer is overwritten
						state <= PREACQ;
					end
				end
				PREACQ: begin
					if (sampleCount == triggerPoint) begin
						state <= WAITING;
					end else if (wrStep) begin
						sampleCount <= sampleCount + 1'b1;
					end
				end
				WAITING: begin
					if (trigger) begin
						sampleCount <= triggerPoint; // post count continues from here
						state <= POSTACQ;
					end
				end
				POSTACQ: begin
					if (postDone) begin
						acquiring <= 1'b0;
						dataReady <= 1'b1;
						state <= INIT;
					end else if (wrStep) begin
						sampleCount <= sampleCount + 1'b1;
					end
				end
				default: state <= INIT;
			endcase
		end
	end

	// address after any step taken on the trigger cycle
	always_ff @(posedge clk_flash) begin
		if (state == WAITING && trigger) begin
			trigPointAddr <= wrAddress + addr_t'(wrStep);
		end
	end

	// buffer stays put between acquisitions so it can be read out
	assert property (@(posedge clk_flash) disable iff (!rstN) !acquiring |=> $stable(wrAddress))
		else $error("acquireControl wrAddress moved while idle");

	assert property (@(posedge clk_flash) disable iff (!rstN) !(dataReady && acquiring))
		else $error("acquireControl dataReady during acquisition");

endmodule

// File: hw/coincidenceTrigger.sv
`timescale 1ns/1ps
`include "scope_consts.svh"

module coincidenceTrigger (
	input logic clk_flash,
	input logic rstN,
	input logic [`SCOPE_NCH-1:0] fire, // per channel self-trigger pulses
	input logic [`SCOPE_NCH-1:0] chanEnable, // channels allowed to trigger
	input triggerPkg::coinCount_t coinReq, // other held channels needed
	input triggerPkg::holdTime_t holdTime, // hold after a fire, dsGo ticks
	input logic allowSameChan, // firing channel counts toward coinReq
	input logic dsGo,
	input logic noSelfTrig, // only pass the right-going chain trigger
	input logic isFirst, // leftmost board
	input logic isLast, // rightmost board
	input triggerPkg::chain_t trigIn, // from the neighbor boards
	output logic trigger, // board trigger to the acquisition
	output triggerPkg::chain_t trigOut // to the neighbor boards
);
	import triggerPkg::*;

	holdTime_t holdLeft [`SCOPE_NCH]; // remaining hold per channel
	logic [`SCOPE_NCH-1:0] fired; // fire lined up with the hold timers
	logic [`SCOPE_NCH-1:0] held; // enabled and still holding
	logic [`SCOPE_NCH-1:0] chanHit; // channel met the coincidence
	coinSum_t nHeld [`SCOPE_NCH]; // held channels seen by each channel
	logic selfTrig;
	logic goingLeft; // trigIn[0] accepted
	logic goingRight; // trigIn[1] accepted

	always_ff @(posedge clk_flash) begin
		if (!rstN) begin
			fired <= '0;
			for (int i = 0; i < `SCOPE_NCH; i++) begin
				holdLeft[i] <= '0;
			end
		end else begin
			fired <= fire;
			for (int i = 0; i < `SCOPE_NCH; i++) begin
				if (fire[i]) begin
					holdLeft[i] <= holdTime; // reload on every fire
				end else if (dsGo && holdLeft[i] != '0) begin
					holdLeft[i] <= holdLeft[i] - 1'b1; // expires in downsampled time
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `SCOPE_NCH; i++) begin
			held[i] = chanEnable[i] && (holdLeft[i] != '0);
		end
		for (int i = 0; i < `SCOPE_NCH; i++) begin
			nHeld[i] = '0;
			for (int j = 0; j < `SCOPE_NCH; j++) begin
				if ((j != i || allowSameChan) && held[j]) begin
					nHeld[i] = nHeld[i] + 1'b1;
				end
			end
			chanHit[i] = chanEnable[i] && fired[i] && (nHeld[i] >= coinSum_t'(coinReq));
		end
	end

	assign selfTrig = |chanHit;
	assign goingLeft = trigIn[0] & ~isFirst; // nothing arrives from beyond the left end
	assign goingRight = trigIn[1] & ~isLast;

	always_ff @(posedge clk_flash) begin
		if (!rstN) begin
			trigger <= 1'b0;
			trigOut <= '0;
		end else if (noSelfTrig) begin
			trigger <= trigIn[1]; // follower board
			trigOut <= {trigIn[1], 1'b0};
		end else begin
			trigger <= selfTrig | goingLeft | goingRight;
			trigOut <= {selfTrig | goingRight, selfTrig | goingLeft};
		end
	end

endmodule

// File: hw/channelTrigger.sv
`timescale 1ns/1ps
`include "scope_consts.svh"

module channelTrigger (
	input logic clk_flash,
	input logic rstN,
	input samplePkg::sample_t sample, // registered adc sample
	input samplePkg::sample_t threshLow, // window bottom, inclusive
	input samplePkg::sample_t threshHigh, // window top, inclusive
	input logic fallingEdge, // 1 fires on leaving the window
	input triggerPkg::tot_t tot, // time over threshold, 0 fires on the edge
	input logic dsGo, // downsample strobe
	output logic fire, // one cycle self-trigger pulse
	output logic inRange // sample was inside the window
);
	import triggerPkg::*;

	logic wasInRange; // inRange one cycle back
	logic edgeSeen; // window entry or exit this cycle
	logic levelHeld; // still on the triggering side
	logic totStep; // counter may advance this cycle
	addr_t totLimit; // counts needed before firing
	tot_t totCount; // 0 means idle

	assign edgeSeen = fallingEdge ? (wasInRange & ~inRange) : (inRange & ~wasInRange);
	assign levelHeld = fallingEdge ? ~inRange : inRange;
	assign totLimit = tot[`SCOPE_TOT_W-2:0];
	assign totStep = ~tot[`SCOPE_TOT_W-1] | dsGo; // every clock unless msb asks for dsGo

	always_ff @(posedge clk_flash) begin
		if (!rstN) begin
			inRange <= 1'b0;
			wasInRange <= 1'b0;
			fire <= 1'b0;
			totCount <= '0;
		end else begin
			inRange <= (sample >= threshLow) && (sample <= threshHigh);
			wasInRange <= inRange;
			if (totLimit == '0) begin
				fire <= edgeSeen; // plain edge trigger
				totCount <= '0;
			end else begin
				fire <= 1'b0;
				if (totCount != '0) begin
					if (totStep) begin
						totCount <= levelHeld ? totCount + 1'b1 : '0; // break clears it
					end
					if (totCount > tot_t'(totLimit)) begin
						fire <= 1'b1; // long enough over threshold
						totCount <= '0; // wait for a fresh edge
					end
				end else if (edgeSeen) begin
					totCount <= tot_t'(1'b1); // start timing the excursion
				end
			end
		end
	end

	// a long excursion must still give a single pulse, the counter restarts only on a new edge
	assert property (@(posedge clk_flash) disable iff (!rstN) fire |=> !fire)
		else $error("channelTrigger fire high for two cycles");

endmodule

// File: hw/triggerPkg.sv
`include "scope_consts.svh"

package triggerPkg;

	typedef logic [`SCOPE_ADDR_W-1:0] addr_t; // ring buffer address or sample count
	typedef logic [`SCOPE_TOT_W-1:0] tot_t; // msb set means count on dsGo only
	typedef logic [`SCOPE_HOLD_W-1:0] holdTime_t; // in dsGo ticks
	typedef logic [1:0] coinCount_t; // other channels required in coincidence
	typedef logic [$clog2(`SCOPE_NCH+1)-1:0] coinSum_t; // held channels seen, 0 to nch
	typedef logic [1:0] chain_t; // [0] runs to the left, [1] runs to the right

	// acquisition sequence
	typedef enum logic [1:0] {
		INIT, // idle, waiting for startTrigger
		PREACQ, // filling the pre-trigger part of the buffer
		WAITING, // buffer rolls until the board trigger
		POSTACQ // filling the post-trigger part
	} acqState_t;

endpackage

// File: hw/samplePkg.sv
`include "scope_consts.svh"

package samplePkg;

	typedef logic [`SCOPE_SAMPLE_W-1:0] sample_t; // one adc conversion

	// sum of up to 2^maxhighres samples without overflow
	typedef logic [`SCOPE_SAMPLE_W+`SCOPE_MAXHIGHRES-1:0] sampleAcc_t;

	typedef logic [`SCOPE_MAXHIGHRES:0] hrCount_t; // samples in the current average

	typedef logic [`SCOPE_DS_W-1:0] dsExp_t; // keep one sample in 2^dsExp

endpackage

// File: hw/scope_consts.svh
`ifndef SCOPE_CONSTS_SVH
`define SCOPE_CONSTS_SVH

// board geometry
`define SCOPE_NCH 4 // flash adc channels per board
`define SCOPE_SAMPLE_W 8 // bits per adc sample

// acquisition buffer
`define SCOPE_ADDR_W 10 // 1024 sample ring buffer
`define SCOPE_DS_W 5 // width of the downsample exponent
`define SCOPE_DS_MAX 22 // largest exponent the strobe counter supports

// high resolution averaging
`define SCOPE_MAXHIGHRES 5 // average over at most 2^5 samples

// self-trigger timing
`define SCOPE_TOT_W (`SCOPE_ADDR_W + 1) // window-edge counter plus the dsGo-only flag
`define SCOPE_HOLD_W 8 // coincidence hold time

`endif
